/* vx_pkg.sv */
package vx_pkg;

  // Scalar register width and XIF instruction id width
  localparam int unsigned XLEN = 32;
  localparam int unsigned ID_W = 4;

  // Operations known to the pre-decoder
  typedef enum logic [2:0] {
    OP_NONE    = 3'd0,
    OP_VSETVLI = 3'd1,
    OP_VSETVL  = 3'd2,
    OP_VADD    = 3'd3,
    OP_VSUB    = 3'd4,
    OP_VAND    = 3'd5
  } vx_op_e;

  // Dispatcher FSM states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    EXEC = 2'd1,
    RESP = 2'd2
  } disp_state_e;

  // One buffered instruction with its scalar operands
  typedef struct packed {
    logic [31:0]     instr;
    logic [ID_W-1:0] id;
    vx_op_e          op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    // Bit 0 for rs1, bit 1 for rs2
    logic [1:0]      rs_valid;
    logic            writeback;
    logic            committed;
  } instr_pack_t;

endpackage

/* vx_instr_if.sv */
interface vx_instr_if;
  import vx_pkg::*;

  logic        valid;
  logic        ready;
  instr_pack_t pack;

  // Ring buffer side
  modport producer (
    output valid,
    output pack,
    input  ready
  );

  // Dispatcher side
  modport consumer (
    input  valid,
    input  pack,
    output ready
  );

endinterface

/* vx_pre_decoder.sv */
module vx_pre_decoder (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           req_valid_i,
  input  logic [31:0]    instr_i,
  output vx_pkg::vx_op_e op_o,
  output logic           accept_o,
  output logic           writeback_o,
  output logic [1:0]     reg_read_o,
  output logic           csr_stall_o
);
  import vx_pkg::*;

  localparam logic [6:0] OPC_OPV = 7'b1010111;

  vx_op_e op_dec;
  vx_op_e last_op_q;
  logic   is_vset;
  logic   vset_pending;

  // Major opcode, then funct3, then funct6 or the vset selector bits
  always_comb begin
    op_dec = OP_NONE;
    if (instr_i[6:0] == OPC_OPV) begin
      if (instr_i[14:12] == 3'b111) begin
        if (!instr_i[31]) begin
          op_dec = OP_VSETVLI;
        end else if (instr_i[30:25] == 6'b000000) begin
          op_dec = OP_VSETVL;
        end
      end else if (instr_i[14:12] == 3'b000) begin
        case (instr_i[31:26])
          6'b000000: op_dec = OP_VADD;
          6'b000010: op_dec = OP_VSUB;
          6'b001001: op_dec = OP_VAND;
          default:   op_dec = OP_NONE;
        endcase
      end
    end
  end

  assign is_vset      = (op_dec == OP_VSETVLI) || (op_dec == OP_VSETVL);
  assign vset_pending = (last_op_q == OP_VSETVLI) || (last_op_q == OP_VSETVL);

  // A vset directly behind a taken vset is refused
  assign op_o        = (is_vset && vset_pending) ? OP_NONE : op_dec;
  assign accept_o    = (op_o != OP_NONE);
  assign writeback_o = (op_o == OP_VSETVLI) || (op_o == OP_VSETVL);
  assign csr_stall_o = req_valid_i && writeback_o;

  // Scalar operands read by each form
  always_comb begin
    case (op_o)
      OP_VSETVLI: reg_read_o = 2'b01;
      OP_VSETVL:  reg_read_o = 2'b11;
      default:    reg_read_o = 2'b00;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_op_q <= OP_NONE;
    end else begin
      last_op_q <= req_valid_i ? op_o : OP_NONE;
    end
  end

endmodule

/* vx_ring_buffer.sv */
module vx_ring_buffer #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  vx_pkg::instr_pack_t         data_i,
  output logic                        full_o,
  input  logic                        reg_valid_i,
  input  logic [vx_pkg::ID_W-1:0]     reg_id_i,
  input  logic [vx_pkg::XLEN-1:0]     rs1_i,
  input  logic [vx_pkg::XLEN-1:0]     rs2_i,
  input  logic                        commit_valid_i,
  input  logic [vx_pkg::ID_W-1:0]     commit_id_i,
  input  logic                        kill_i,
  vx_instr_if.producer                out_o
);
  import vx_pkg::*;

  // Pointers wrap naturally, so DEPTH is a power of two
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  instr_pack_t      mem_q [DEPTH];
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] keep_cnt;
  logic [PTR_W-1:0] offs [DEPTH];
  logic [DEPTH-1:0] used;
  logic             head_ok;
  logic             pop;
  instr_pack_t      push_entry;

  // Slot occupancy from its distance to the head
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      offs[i] = PTR_W'(i) - head_q;
      used[i] = (CNT_W'(offs[i]) < count_q);
    end
  end

  // Length of the committed run starting at the head
  always_comb begin : keep_scan
    logic stop;
    keep_cnt = '0;
    stop     = 1'b0;
    for (int k = 0; k < DEPTH; k++) begin
      if (!stop && (CNT_W'(k) < count_q) && mem_q[head_q + PTR_W'(k)].committed) begin
        keep_cnt = keep_cnt + 1'b1;
      end else begin
        stop = 1'b1;
      end
    end
  end

  // Registers or commit may come in the issue cycle itself
  always_comb begin
    push_entry = data_i;
    if (reg_valid_i && (reg_id_i == data_i.id)) begin
      push_entry.rs1      = rs1_i;
      push_entry.rs2      = rs2_i;
      push_entry.rs_valid = 2'b11;
    end
    if (commit_valid_i && (commit_id_i == data_i.id)) begin
      push_entry.committed = 1'b1;
    end
  end

  assign head_ok = (count_q != '0) && mem_q[head_q].committed && (&mem_q[head_q].rs_valid);
  assign pop     = head_ok && out_o.ready;
  assign full_o  = (count_q == CNT_W'(DEPTH));

  assign out_o.valid = head_ok;
  assign out_o.pack  = mem_q[head_q];

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < DEPTH; i++) begin
      if (used[i] && reg_valid_i && (mem_q[i].id == reg_id_i)) begin
        mem_q[i].rs1      <= rs1_i;
        mem_q[i].rs2      <= rs2_i;
        mem_q[i].rs_valid <= 2'b11;
      end
      if (used[i] && commit_valid_i && (mem_q[i].id == commit_id_i)) begin
        mem_q[i].committed <= 1'b1;
      end
    end
    if (push_i) begin
      mem_q[tail_q] <= push_entry;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      if (kill_i) begin
        // Drop everything behind the committed run
        tail_q  <= head_q + PTR_W'(keep_cnt);
        count_q <= keep_cnt - CNT_W'(pop);
      end else begin
        if (push_i) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
      end
    end
  end

endmodule

/* vx_xif_handler.sv */
module vx_xif_handler #(
  parameter int unsigned DEPTH = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    issue_valid_i,
  input  logic [31:0]             issue_instr_i,
  input  logic [vx_pkg::ID_W-1:0] issue_id_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output logic                    issue_writeback_o,
  output logic [1:0]              issue_reg_read_o,
  input  logic                    register_valid_i,
  input  logic [vx_pkg::ID_W-1:0] register_id_i,
  input  logic [vx_pkg::XLEN-1:0] register_rs1_i,
  input  logic [vx_pkg::XLEN-1:0] register_rs2_i,
  output logic                    register_ready_o,
  input  logic                    commit_valid_i,
  input  logic [vx_pkg::ID_W-1:0] commit_id_i,
  input  logic                    commit_kill_i,
  vx_instr_if.producer            out_o
);
  import vx_pkg::*;

  logic            kill;
  logic            commit;
  logic            buffer_full;
  logic            issue_xfer;
  logic            push;
  vx_op_e          dec_op;
  logic            dec_accept;
  logic            dec_writeback;
  logic [1:0]      dec_reg_read;
  logic            dec_csr_stall;
  logic            stall_d, stall_q;
  logic [ID_W-1:0] stall_id_d, stall_id_q;
  instr_pack_t     pack;

  assign kill   = commit_valid_i && commit_kill_i;
  assign commit = commit_valid_i && !commit_kill_i;

  assign issue_ready_o = issue_valid_i && !buffer_full && !kill && !stall_q;
  assign issue_xfer    = issue_valid_i && issue_ready_o;
  assign push          = issue_xfer && dec_accept;

  assign issue_accept_o    = issue_xfer && dec_accept;
  assign issue_writeback_o = issue_xfer && dec_writeback;
  assign issue_reg_read_o  = issue_xfer ? dec_reg_read : 2'b00;
  assign register_ready_o  = register_valid_i;

  vx_pre_decoder i_pre_decoder (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (issue_xfer),
    .instr_i     (issue_instr_i),
    .op_o        (dec_op),
    .accept_o    (dec_accept),
    .writeback_o (dec_writeback),
    .reg_read_o  (dec_reg_read),
    .csr_stall_o (dec_csr_stall)
  );

  // Operands not read by the instruction count as already present
  always_comb begin
    pack           = '0;
    pack.instr     = issue_instr_i;
    pack.id        = issue_id_i;
    pack.op        = dec_op;
    pack.rs_valid  = ~dec_reg_read;
    pack.writeback = dec_writeback;
  end

  vx_ring_buffer #(
    .DEPTH (DEPTH)
  ) i_ring_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .data_i         (pack),
    .full_o         (buffer_full),
    .reg_valid_i    (register_valid_i),
    .reg_id_i       (register_id_i),
    .rs1_i          (register_rs1_i),
    .rs2_i          (register_rs2_i),
    .commit_valid_i (commit),
    .commit_id_i    (commit_id_i),
    .kill_i         (kill),
    .out_o          (out_o)
  );

  // Hold issue until the vset operands are in
  always_comb begin
    stall_d    = stall_q;
    stall_id_d = stall_id_q;
    if (dec_csr_stall && !(register_valid_i && (register_id_i == issue_id_i))) begin
      stall_d    = 1'b1;
      stall_id_d = issue_id_i;
    end
    if (stall_q && register_valid_i && (register_id_i == stall_id_q)) begin
      stall_d = 1'b0;
    end
    if (kill) begin
      stall_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stall_q    <= 1'b0;
      stall_id_q <= '0;
    end else begin
      stall_q    <= stall_d;
      stall_id_q <= stall_id_d;
    end
  end

endmodule

/* vx_dispatcher.sv */
module vx_dispatcher #(
  parameter int unsigned VLEN = 128
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  vx_instr_if.consumer            in_i,
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output logic [vx_pkg::ID_W-1:0] result_id_o,
  output logic [4:0]              result_rd_o,
  output logic [vx_pkg::XLEN-1:0] result_data_o
);
  import vx_pkg::*;

  disp_state_e     state_q;
  instr_pack_t     cur_q;
  logic [XLEN-1:0] vl_q;
  logic [XLEN-1:0] vtype_q;
  logic [XLEN-1:0] vtype_new;
  logic [XLEN-1:0] vlmax;
  logic [XLEN-1:0] vl_new;
  logic [1:0]      sew_sh;
  logic [1:0]      lmul_sh;
  logic            is_vset_in;
  logic            take;

  assign in_i.ready = (state_q == IDLE);
  assign take       = in_i.valid && (state_q == IDLE);
  assign is_vset_in = (in_i.pack.op == OP_VSETVLI) || (in_i.pack.op == OP_VSETVL);

  // zimm for vsetvli, rs2 for vsetvl
  assign vtype_new = (in_i.pack.op == OP_VSETVLI) ? XLEN'(in_i.pack.instr[27:20])
                                                  : in_i.pack.rs2;

  // SEW 8..64 and LMUL 1..8
  assign sew_sh  = (vtype_q[5:3] > 3'd3) ? 2'd3 : vtype_q[4:3];
  assign lmul_sh = (vtype_q[2:0] > 3'd3) ? 2'd3 : vtype_q[1:0];
  assign vlmax   = (XLEN'(VLEN) >> (3 + sew_sh)) << lmul_sh;
  assign vl_new  = (cur_q.rs1 < vlmax) ? cur_q.rs1 : vlmax;

  always_ff @(posedge clk_i) begin
    if (take) begin
      cur_q <= in_i.pack;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      vl_q    <= '0;
      vtype_q <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (take) begin
            state_q <= EXEC;
            if (is_vset_in) begin
              vtype_q <= vtype_new;
            end
          end
        end
        EXEC: begin
          // Arithmetic retires here without a result
          if (cur_q.writeback) begin
            vl_q    <= vl_new;
            state_q <= RESP;
          end else begin
            state_q <= IDLE;
          end
        end
        RESP: begin
          if (result_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign result_valid_o = (state_q == RESP);
  assign result_id_o    = cur_q.id;
  assign result_rd_o    = cur_q.instr[11:7];
  assign result_data_o  = vl_q;

endmodule

/* vx_top.sv */
module vx_top #(
  parameter int unsigned DEPTH = 4,
  parameter int unsigned VLEN  = 128
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Issue channel
  input  logic                    issue_valid_i,
  input  logic [31:0]             issue_instr_i,
  input  logic [vx_pkg::ID_W-1:0] issue_id_i,
  output logic                    issue_ready_o,
  output logic                    issue_accept_o,
  output logic                    issue_writeback_o,
  output logic [1:0]              issue_reg_read_o,
  // Register channel
  input  logic                    register_valid_i,
  input  logic [vx_pkg::ID_W-1:0] register_id_i,
  input  logic [vx_pkg::XLEN-1:0] register_rs1_i,
  input  logic [vx_pkg::XLEN-1:0] register_rs2_i,
  output logic                    register_ready_o,
  // Commit channel
  input  logic                    commit_valid_i,
  input  logic [vx_pkg::ID_W-1:0] commit_id_i,
  input  logic                    commit_kill_i,
  // Result channel
  output logic                    result_valid_o,
  input  logic                    result_ready_i,
  output logic [vx_pkg::ID_W-1:0] result_id_o,
  output logic [4:0]              result_rd_o,
  output logic [vx_pkg::XLEN-1:0] result_data_o
);

  vx_instr_if instr_if ();

  vx_xif_handler #(
    .DEPTH (DEPTH)
  ) i_xif_handler (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .issue_valid_i     (issue_valid_i),
    .issue_instr_i     (issue_instr_i),
    .issue_id_i        (issue_id_i),
    .issue_ready_o     (issue_ready_o),
    .issue_accept_o    (issue_accept_o),
    .issue_writeback_o (issue_writeback_o),
    .issue_reg_read_o  (issue_reg_read_o),
    .register_valid_i  (register_valid_i),
    .register_id_i     (register_id_i),
    .register_rs1_i    (register_rs1_i),
    .register_rs2_i    (register_rs2_i),
    .register_ready_o  (register_ready_o),
    .commit_valid_i    (commit_valid_i),
    .commit_id_i       (commit_id_i),
    .commit_kill_i     (commit_kill_i),
    .out_o             (instr_if.producer)
  );

  vx_dispatcher #(
    .VLEN (VLEN)
  ) i_dispatcher (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .in_i           (instr_if.consumer),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_id_o    (result_id_o),
    .result_rd_o    (result_rd_o),
    .result_data_o  (result_data_o)
  );

endmodule

/* tb_clkgen.sv */
module tb_clkgen #(
  parameter int unsigned PERIOD_NS    = 20,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Release away from the clock edge
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

/* vx_assertions.sv */
module vx_assertions (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    issue_ready_i,
  input logic                    commit_valid_i,
  input logic                    commit_kill_i,
  input logic                    result_valid_i,
  input logic                    result_ready_i,
  input logic [vx_pkg::ID_W-1:0] result_id_i,
  input logic [4:0]              result_rd_i,
  input logic [vx_pkg::XLEN-1:0] result_data_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;

  // Result payload holds while the core stalls the channel
  result_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_valid_i && !result_ready_i) |=> (result_valid_i && $stable(result_id_i)
      && $stable(result_rd_i) && $stable(result_data_i)))
    else begin
      fail_cnt++;
      $error("result channel changed while valid and not ready");
    end

  no_ready_on_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_valid_i && commit_kill_i) |-> !issue_ready_i)
    else begin
      fail_cnt++;
      $error("issue_ready_o high in a kill cycle");
    end

  // No result offered in the first cycle out of reset
  result_low_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !result_valid_i)
    else begin
      fail_cnt++;
      $error("result_valid_o high right after reset");
    end

endmodule

bind vx_top vx_assertions i_assertions (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .issue_ready_i  (issue_ready_o),
  .commit_valid_i (commit_valid_i),
  .commit_kill_i  (commit_kill_i),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_id_i    (result_id_o),
  .result_rd_i    (result_rd_o),
  .result_data_i  (result_data_o)
);

/* tb_vx_top.sv */
module tb_vx_top;
  timeunit 1ns;
  timeprecision 100ps;
  import vx_pkg::*;

  localparam int unsigned DEPTH   = 4;
  localparam int unsigned VLEN    = 128;
  localparam int unsigned TIMEOUT = 200;

  logic            clk;
  logic            rst_n;
  logic            issue_valid;
  logic [31:0]     issue_instr;
  logic [ID_W-1:0] issue_id;
  logic            issue_ready;
  logic            issue_accept;
  logic            issue_writeback;
  logic [1:0]      issue_reg_read;
  logic            reg_valid;
  logic [ID_W-1:0] reg_id;
  logic [XLEN-1:0] reg_rs1;
  logic [XLEN-1:0] reg_rs2;
  logic            reg_ready;
  logic            commit_valid;
  logic [ID_W-1:0] commit_id;
  logic            commit_kill;
  logic            result_valid;
  logic            result_ready;
  logic [ID_W-1:0] result_id;
  logic [4:0]      result_rd;
  logic [XLEN-1:0] result_data;

  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_start = 0;
  int          hold_cnt = 0;
  string       test_name = "";
  logic [7:0]  lfsr = 8'd38;

  // Results seen on the channel, in arrival order
  logic [ID_W-1:0] res_id_q[$];
  logic [4:0]      res_rd_q[$];
  logic [XLEN-1:0] res_data_q[$];

  tb_clkgen #(.PERIOD_NS(20), .RESET_CYCLES(4)) i_clkgen (.clk_o(clk), .rst_no(rst_n));

  vx_top #(
    .DEPTH (DEPTH),
    .VLEN  (VLEN)
  ) dut0 (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .issue_valid_i     (issue_valid),
    .issue_instr_i     (issue_instr),
    .issue_id_i        (issue_id),
    .issue_ready_o     (issue_ready),
    .issue_accept_o    (issue_accept),
    .issue_writeback_o (issue_writeback),
    .issue_reg_read_o  (issue_reg_read),
    .register_valid_i  (reg_valid),
    .register_id_i     (reg_id),
    .register_rs1_i    (reg_rs1),
    .register_rs2_i    (reg_rs2),
    .register_ready_o  (reg_ready),
    .commit_valid_i    (commit_valid),
    .commit_id_i       (commit_id),
    .commit_kill_i     (commit_kill),
    .result_valid_o    (result_valid),
    .result_ready_i    (result_ready),
    .result_id_o       (result_id),
    .result_rd_o       (result_rd),
    .result_data_o     (result_data)
  );

  // x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s %s: expected 0x%0h actual 0x%0h", test_name, what, exp, act);
    end
  endtask

  task automatic report_problem(input string msg);
    errors++;
    $display("Error in %s: %s", test_name, msg);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic close_test();
    if (test_name != "") begin
      tests_run++;
      if (errors == test_start) begin
        $display("Test %s finished: ok", test_name);
      end else begin
        tests_failed++;
        $display("Test %s finished: %0d errors", test_name, errors - test_start);
      end
    end
  endtask

  task automatic send_issue(input logic [31:0] instr, input logic [ID_W-1:0] id,
                            input logic acc, input logic wb, input logic [1:0] rr);
    int n;
    n = 0;
    issue_valid = 1'b1;
    issue_instr = instr;
    issue_id    = id;
    @(negedge clk);
    while (!issue_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (issue_ready) begin
      check_value($sformatf("accept of id %0d", id), acc, issue_accept);
      check_value($sformatf("writeback of id %0d", id), wb, issue_writeback);
      check_value($sformatf("reg_read of id %0d", id), rr, issue_reg_read);
    end else begin
      report_problem($sformatf("issue_ready_o never rose for id %0d", id));
    end
    next_cycle();
    issue_valid = 1'b0;
  endtask

  // Issue held for a number of cycles that must all see ready low
  task automatic hold_issue_blocked(input logic [31:0] instr, input logic [ID_W-1:0] id,
                                    input int cycles);
    issue_valid = 1'b1;
    issue_instr = instr;
    issue_id    = id;
    repeat (cycles) begin
      @(negedge clk);
      check_value("issue_ready_o while blocked", 1'b0, issue_ready);
      next_cycle();
    end
    issue_valid = 1'b0;
  endtask

  task automatic send_regs(input logic [ID_W-1:0] id, input logic [31:0] rs1,
                           input logic [31:0] rs2);
    reg_valid = 1'b1;
    reg_id    = id;
    reg_rs1   = rs1;
    reg_rs2   = rs2;
    @(negedge clk);
    check_value("register_ready_o", 1'b1, reg_ready);
    next_cycle();
    reg_valid = 1'b0;
  endtask

  task automatic send_commit(input logic [ID_W-1:0] id, input logic kill);
    commit_valid = 1'b1;
    commit_id    = id;
    commit_kill  = kill;
    // The core keeps offering its next instruction through a kill
    if (kill) begin
      issue_valid = 1'b1;
      @(negedge clk);
      check_value("issue_ready_o during kill", 1'b0, issue_ready);
    end
    next_cycle();
    issue_valid  = 1'b0;
    commit_valid = 1'b0;
    commit_kill  = 1'b0;
  endtask

  task automatic wait_result(input logic [ID_W-1:0] id, input logic [4:0] rd,
                             input logic [31:0] data);
    int              n;
    logic [ID_W-1:0] got_id;
    logic [4:0]      got_rd;
    logic [XLEN-1:0] got_data;
    n = 0;
    while (res_id_q.size() == 0 && n < TIMEOUT) begin
      next_cycle();
      n++;
    end
    if (res_id_q.size() == 0) begin
      report_problem($sformatf("no result arrived for id %0d", id));
    end else begin
      got_id   = res_id_q.pop_front();
      got_rd   = res_rd_q.pop_front();
      got_data = res_data_q.pop_front();
      check_value("result id", id, got_id);
      check_value($sformatf("result rd of id %0d", id), rd, got_rd);
      check_value($sformatf("vl of id %0d", id), data, got_data);
    end
  endtask

  task automatic hold_ready_low(input int cycles);
    @(negedge clk);
    hold_cnt = cycles;
    next_cycle();
  endtask

  // Result ready follows the LFSR unless a hold is running
  initial begin
    result_ready = 1'b0;
    forever begin
      next_cycle();
      if (hold_cnt > 0) begin
        result_ready = 1'b0;
        hold_cnt--;
      end else begin
        lfsr = lfsr_step(lfsr);
        result_ready = lfsr[0];
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && result_valid && result_ready) begin
      res_id_q.push_back(result_id);
      res_rd_q.push_back(result_rd);
      res_data_q.push_back(result_data);
    end
  end

  initial begin
    int          fd;
    int          n;
    int          code;
    int          x;
    int          y;
    int          z;
    string       cmd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  rr;
    issue_valid  = 1'b0;
    issue_instr  = '0;
    issue_id     = '0;
    reg_valid    = 1'b0;
    reg_id       = '0;
    reg_rs1      = '0;
    reg_rs2      = '0;
    commit_valid = 1'b0;
    commit_id    = '0;
    commit_kill  = 1'b0;
    n = 0;
    while (rst_n !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    next_cycle();
    test_name  = "reset";
    test_start = errors;
    if (rst_n !== 1'b1) begin
      report_problem("reset was never released");
    end
    check_value("issue_ready_o", 1'b0, issue_ready);
    check_value("issue_accept_o", 1'b0, issue_accept);
    check_value("result_valid_o", 1'b0, result_valid);
    close_test();
    test_name = "";

    fd = $fopen("vx_stimulus.txt", "r");
    if (fd == 0) begin
      report_problem("could not open vx_stimulus.txt");
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        if (cmd.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
        end else if (cmd == "test") begin
          close_test();
          code = $fscanf(fd, "%s", test_name);
          test_start = errors;
        end else if (cmd == "issue") begin
          code = $fscanf(fd, "%h %d %d %d %b", a, x, y, z, rr);
          send_issue(a, x[ID_W-1:0], y[0], z[0], rr);
        end else if (cmd == "blocked") begin
          code = $fscanf(fd, "%h %d %d", a, x, y);
          hold_issue_blocked(a, x[ID_W-1:0], y);
        end else if (cmd == "reg") begin
          code = $fscanf(fd, "%d %h %h", x, a, b);
          send_regs(x[ID_W-1:0], a, b);
        end else if (cmd == "commit") begin
          code = $fscanf(fd, "%d %d", x, y);
          send_commit(x[ID_W-1:0], y[0]);
        end else if (cmd == "expect_result") begin
          code = $fscanf(fd, "%d %d %d", x, y, z);
          wait_result(x[ID_W-1:0], y[4:0], z);
        end else if (cmd == "stall_ready") begin
          code = $fscanf(fd, "%d", x);
          hold_ready_low(x);
        end else begin
          report_problem($sformatf("unknown command %s in stimulus file", cmd));
        end
      end
      $fclose(fd);
      // Buffered arithmetic still has to retire without a result
      n = 0;
      while (res_id_q.size() == 0 && !result_valid && n < 3 * (DEPTH + 1)) begin
        next_cycle();
        n++;
      end
      if (res_id_q.size() != 0) begin
        report_problem($sformatf("unexpected result with id %0d", res_id_q[0]));
      end else if (result_valid) begin
        report_problem($sformatf("unexpected result with id %0d", result_id));
      end
      close_test();
    end

    errors += dut0.i_assertions.fail_cnt;
    $display("Tests: %0d run, %0d failed, %0d checks, %0d errors, %0d assertion failures",
             tests_run, tests_failed, checks, errors, dut0.i_assertions.fail_cnt);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* vlog.f */
vx_pkg.sv
vx_instr_if.sv
vx_pre_decoder.sv
vx_ring_buffer.sv
vx_xif_handler.sv
vx_dispatcher.sv
vx_top.sv
tb_clkgen.sv
vx_assertions.sv
tb_vx_top.sv

/* vx_stimulus.txt */
# Columns: command then fields; instr, rs1 and rs2 in hex, reg_read in binary, others decimal
# issue instr id accept writeback reg_read / blocked instr id cycles / reg id rs1 rs2
# commit id kill / expect_result id rd vl / stall_ready cycles / test name
test classify
issue 022180D7 1 1 0 00
issue 0A2180D7 2 1 0 00
issue 262180D7 3 1 0 00
issue 00100093 4 0 0 00
commit 1 0
commit 2 0
commit 3 0
test vsetvli_e32m1
issue 010572D7 5 1 1 01
reg 5 00000014 00000000
commit 5 0
expect_result 5 5 4
test vsetvli_e8m2
issue 0015F357 6 1 1 01
reg 6 00000014 00000000
commit 6 0
expect_result 6 6 20
test csr_stall
issue 010572D7 7 1 1 01
blocked 022180D7 8 4
reg 7 00000002 00000000
issue 022180D7 8 1 0 00
commit 7 0
commit 8 0
expect_result 7 5 2
test kill
issue 0015F357 9 1 1 01
blocked 022180D7 10 3
commit 9 1
issue 010572D7 10 1 1 01
reg 10 00000064 00000000
commit 10 0
expect_result 10 5 4
test vsetvl
issue 80D673D7 11 1 1 11
reg 11 00000032 0000000A
commit 11 0
expect_result 11 7 32
issue 80D673D7 3 1 1 11
reg 3 0000000C 0000001B
commit 3 0
expect_result 3 7 12
test backpressure
stall_ready 60
issue 010572D7 12 1 1 01
reg 12 00000003 00000000
commit 12 0
issue 0015F357 13 1 1 01
reg 13 00000028 00000000
commit 13 0
issue 80D673D7 14 1 1 11
reg 14 00000064 00000000
commit 14 0
issue 022180D7 15 1 0 00
issue 0A2180D7 0 1 0 00
blocked 262180D7 1 4
commit 15 0
commit 0 0
expect_result 12 5 3
expect_result 13 6 32
expect_result 14 7 16
